/* Bender.yml */
package:
  name: stream_combiner

sources:
  # Design sources in compile order
  - files:
      - combiner_pkg.sv
      - combiner_config_regs.sv
      - stream_skid_buffer.sv
      - rr_stream_mux.sv
      - stream_combiner.sv

  # Testbench and bound checker
  - target: test
    files:
      - stream_combiner_checker.sv
      - stream_combiner_tb.sv

/* build.f */
combiner_pkg.sv
combiner_config_regs.sv
stream_skid_buffer.sv
rr_stream_mux.sv
stream_combiner.sv
stream_combiner_checker.sv
stream_combiner_tb.sv

/* combiner_config_regs.sv */
`timescale 1ns/1ps
/*
 * Stream combiner configuration registers
 * Holds the input enable mask and one destination tag per input, single-cycle writes
 */
module combiner_config_regs #(
    parameter int NUM_INPUTS = 6
) (
    input  logic                                              clock,
    input  logic                                              arst_n,
    input  logic                                              cfg_we,
    input  logic [combiner_pkg::CFG_ADDR_W-1:0]               cfg_addr,
    input  combiner_pkg::cfg_word_u                           cfg_wdata,
    output combiner_pkg::cfg_word_u                           cfg_rdata,
    output logic [NUM_INPUTS-1:0]                             enable_mask,
    output logic [NUM_INPUTS-1:0][combiner_pkg::DEST_W-1:0]   dest_tags
);

    // Address decode, shared by the write and the read-back path
    logic                  ctrl_hit;
    logic [NUM_INPUTS-1:0] tag_hit;

    assign ctrl_hit = (cfg_addr == combiner_pkg::CFG_ADDR_CTRL);

    // Each input owns exactly one tag address above the control word
    // Anything past the last input matches no bit and is simply ignored
    always_comb begin
        for (int k = 0; k < NUM_INPUTS; k++) begin
            tag_hit[k] = (cfg_addr == combiner_pkg::CFG_ADDR_TAG_BASE
                                      + k[combiner_pkg::CFG_ADDR_W-1:0]);
        end
    end

    // Register writes take effect on the edge where the strobe is high
    // Reset enables every input and gives input k the tag k
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            enable_mask <= '1;
            for (int k = 0; k < NUM_INPUTS; k++) begin
                dest_tags[k] <= k[combiner_pkg::DEST_W-1:0];
            end
        end else if (cfg_we) begin
            // Control address, the word is taken through the ctrl view
            if (ctrl_hit) begin
                enable_mask <= cfg_wdata.ctrl.enable[NUM_INPUTS-1:0];
            end
            // Tag address, the word is taken through the tag view
            for (int k = 0; k < NUM_INPUTS; k++) begin
                if (tag_hit[k]) begin
                    dest_tags[k] <= cfg_wdata.tag.dest;
                end
            end
        end
    end

    // Read-back is combinational on the current address
    // Reserved bits and unmapped addresses read as zero
    always_comb begin
        cfg_rdata = '0;
        if (ctrl_hit) begin
            cfg_rdata.ctrl.enable[NUM_INPUTS-1:0] = enable_mask;
        end
        for (int k = 0; k < NUM_INPUTS; k++) begin
            if (tag_hit[k]) begin
                cfg_rdata.tag.dest = dest_tags[k];
            end
        end
    end

endmodule

/* combiner_pkg.sv */
/*
 * Stream combiner shared definitions
 * Payload and tag widths, the output beat, the configuration word and its addresses
 */
package combiner_pkg;

    // Stream payload width, fixed for the whole fabric
    localparam int DATA_W = 32;

    // Destination tag width carried next to every output beat
    localparam int DEST_W = 4;

    // Largest input count, which is also the width of the enable mask
    localparam int MAX_INPUTS = 8;

    // Configuration word and address widths
    localparam int CFG_W = 32;
    localparam int CFG_ADDR_W = 4;

    // Control word sits at address zero
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_CTRL = 4'd0;

    // Tag of input k sits at this base plus k
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_TAG_BASE = 4'd1;

    // One output beat with its destination tag
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [DEST_W-1:0] dest;
    } beat_t;

    // Control view, one enable bit per input in the low bits
    typedef struct packed {
        logic [CFG_W-MAX_INPUTS-1:0] rsvd;
        logic [MAX_INPUTS-1:0]       enable;
    } cfg_ctrl_t;

    // Tag view, the destination tag in the low bits
    typedef struct packed {
        logic [CFG_W-DEST_W-1:0] rsvd;
        logic [DEST_W-1:0]       dest;
    } cfg_tag_t;

    // The same word is read through one view or the other depending on the address
    typedef union packed {
        cfg_ctrl_t ctrl;
        cfg_tag_t  tag;
    } cfg_word_u;

endpackage

/* rr_stream_mux.sv */
`timescale 1ns/1ps
/*
 * Round-robin stream multiplexer
 * Grants one enabled input per cycle, adds its tag and registers the output beat
 */
module rr_stream_mux #(
    parameter int NUM_INPUTS = 6
) (
    input  logic                                              clock,
    input  logic                                              arst_n,
    input  logic [NUM_INPUTS-1:0]                             buf_valid,
    input  logic [NUM_INPUTS-1:0][combiner_pkg::DATA_W-1:0]   buf_data,
    output logic [NUM_INPUTS-1:0]                             buf_ready,
    input  logic [NUM_INPUTS-1:0]                             enable_mask,
    input  logic [NUM_INPUTS-1:0][combiner_pkg::DEST_W-1:0]   dest_tags,
    output logic                                              out_valid,
    output combiner_pkg::beat_t                               out_beat,
    input  logic                                              out_ready
);

    // Pointer width, kept at one bit for a single input
    localparam int PTR_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

    // Round-robin pointer, the input that has first claim next cycle
    logic [PTR_W-1:0] rr_ptr;

    // Inputs that may compete this cycle
    logic [NUM_INPUTS-1:0] req;

    logic             grant_found;
    logic [PTR_W-1:0] grant_idx;
    logic             out_load;
    logic             grant;

    // Masked inputs never request, so their beats wait in their buffers
    assign req = buf_valid & enable_mask;

    // Output register accepts a new beat when empty or sending this cycle
    assign out_load = ~out_valid | out_ready;
    assign grant    = out_load & grant_found;

    // Search starts at the pointer and wraps around once
    always_comb begin : arb_search
        int idx;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            idx = int'(rr_ptr) + i;
            if (idx >= NUM_INPUTS) begin
                idx = idx - NUM_INPUTS;
            end
            // first hit wins, later candidates are ignored
            if (!grant_found && req[idx]) begin
                grant_found = 1'b1;
                grant_idx   = idx[PTR_W-1:0];
            end
        end
    end

    // Ready goes back to the winner only
    always_comb begin
        buf_ready = '0;
        if (grant) begin
            buf_ready[grant_idx] = 1'b1;
        end
    end

    // Valid flag and pointer
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            rr_ptr    <= '0;
        end else begin
            if (out_load) begin
                out_valid <= grant_found;
            end
            // After a grant the input behind the winner gets first claim
            if (grant) begin
                if (grant_idx == PTR_W'(NUM_INPUTS - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= grant_idx + 1'b1;
                end
            end
        end
    end

    // Output payload, the tag is sampled at grant time
    // so a later tag rewrite never changes a beat already in flight
    always_ff @(posedge clock) begin
        if (grant) begin
            out_beat.data <= buf_data[grant_idx];
            out_beat.dest <= dest_tags[grant_idx];
        end
    end

endmodule

/* stream_combiner.sv */
`timescale 1ns/1ps
/*
 * Stream combiner top level
 * Skid-buffers each input stream and merges them round robin into one tagged output
 */
module stream_combiner #(
    parameter int NUM_INPUTS = 6
) (
    input  logic                                              clock,
    input  logic                                              arst_n,
    input  logic [NUM_INPUTS-1:0]                             in_valid,
    input  logic [NUM_INPUTS-1:0][combiner_pkg::DATA_W-1:0]   in_data,
    output logic [NUM_INPUTS-1:0]                             in_ready,
    input  logic                                              cfg_we,
    input  logic [combiner_pkg::CFG_ADDR_W-1:0]               cfg_addr,
    input  combiner_pkg::cfg_word_u                           cfg_wdata,
    output combiner_pkg::cfg_word_u                           cfg_rdata,
    output logic                                              out_valid,
    output combiner_pkg::beat_t                               out_beat,
    input  logic                                              out_ready
);

    // Configuration to mux
    logic [NUM_INPUTS-1:0]                           enable_mask;
    logic [NUM_INPUTS-1:0][combiner_pkg::DEST_W-1:0] dest_tags;

    // Buffers to mux
    logic [NUM_INPUTS-1:0]                           buf_valid;
    logic [NUM_INPUTS-1:0][combiner_pkg::DATA_W-1:0] buf_data;
    logic [NUM_INPUTS-1:0]                           buf_ready;

    // Enable mask and destination tags
    combiner_config_regs #(
        .NUM_INPUTS (NUM_INPUTS)
    ) i_config_regs (
        .clock       (clock),
        .arst_n      (arst_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .enable_mask (enable_mask),
        .dest_tags   (dest_tags)
    );

    // One skid buffer per input keeps the ready path short
    for (genvar k = 0; k < NUM_INPUTS; k++) begin : g_input
        stream_skid_buffer i_skid_buffer (
            .clock     (clock),
            .arst_n    (arst_n),
            .in_valid  (in_valid[k]),
            .in_data   (in_data[k]),
            .in_ready  (in_ready[k]),
            .buf_valid (buf_valid[k]),
            .buf_data  (buf_data[k]),
            .buf_ready (buf_ready[k])
        );
    end

    // Arbiter and registered output stage
    rr_stream_mux #(
        .NUM_INPUTS (NUM_INPUTS)
    ) i_mux (
        .clock       (clock),
        .arst_n      (arst_n),
        .buf_valid   (buf_valid),
        .buf_data    (buf_data),
        .buf_ready   (buf_ready),
        .enable_mask (enable_mask),
        .dest_tags   (dest_tags),
        .out_valid   (out_valid),
        .out_beat    (out_beat),
        .out_ready   (out_ready)
    );

endmodule

/* stream_combiner_checker.sv */
`timescale 1ns/1ps
/*
 * Stream combiner handshake checker
 * Bound to the top level, watches the output hold rule, reset state and masked inputs
 */
module stream_combiner_checker #(
    parameter int NUM_INPUTS = 6
) (
    input logic                                              clock,
    input logic                                              arst_n,
    input logic [NUM_INPUTS-1:0]                             in_ready,
    input logic                                              out_valid,
    input combiner_pkg::beat_t                               out_beat,
    input logic                                              out_ready,
    input logic [NUM_INPUTS-1:0]                             enable_mask,
    input logic [NUM_INPUTS-1:0][combiner_pkg::DEST_W-1:0]   dest_tags
);

    // Number of assertion failures seen so far
    int unsigned fail_count = 0;

    // A stalled output beat keeps its valid and its payload until it is taken
    assert property (@(posedge clock) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else begin
            fail_count++;
            $error("Output beat changed or dropped while stalled");
        end

    // The reset is asynchronous, so both ready and valid read low at every edge inside it
    assert property (@(posedge clock)
        !arst_n |-> (!out_valid && (in_ready == '0)))
        else begin
            fail_count++;
            $error("Output valid or input ready high during reset");
        end

    // A fresh beat was granted one edge earlier, so mask and tags are taken from there
    for (genvar k = 0; k < NUM_INPUTS; k++) begin : g_masked
        assert property (@(posedge clock) disable iff (!arst_n)
            (out_valid && (!$past(out_valid) || $past(out_ready)) && !$past(enable_mask[k]))
            |-> (out_beat.dest != $past(dest_tags[k])))
            else begin
                fail_count++;
                $error("Disabled input %0d was granted", k);
            end
    end

endmodule

// Attach the checker to every instance of the top level
bind stream_combiner stream_combiner_checker #(
    .NUM_INPUTS (NUM_INPUTS)
) i_checker (
    .clock       (clock),
    .arst_n      (arst_n),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_beat    (out_beat),
    .out_ready   (out_ready),
    .enable_mask (enable_mask),
    .dest_tags   (dest_tags)
);

/* stream_combiner_tb.sv */
`timescale 1ns/1ps
/*
 * Stream combiner testbench
 * Random input traffic, configuration writes and read-back, per-tag scoreboard
 */
module stream_combiner_tb;

    localparam int NUM_INPUTS = 6;
    localparam int NUM_TAGS   = 2 ** combiner_pkg::DEST_W;
    localparam int TIMEOUT    = 3000;

    logic                                              clock;
    logic                                              arst_n;
    logic [NUM_INPUTS-1:0]                             in_valid;
    logic [NUM_INPUTS-1:0][combiner_pkg::DATA_W-1:0]   in_data;
    logic [NUM_INPUTS-1:0]                             in_ready;
    logic                                              cfg_we;
    logic [combiner_pkg::CFG_ADDR_W-1:0]               cfg_addr;
    combiner_pkg::cfg_word_u                           cfg_wdata;
    combiner_pkg::cfg_word_u                           cfg_rdata;
    logic                                              out_valid;
    combiner_pkg::beat_t                               out_beat;
    logic                                              out_ready;

    // Shadow of the configuration that follows each write once it has landed
    logic [NUM_INPUTS-1:0]           shadow_mask;
    logic [combiner_pkg::DEST_W-1:0] shadow_tags [NUM_INPUTS];

    // One queue of expected data words per destination tag
    logic [combiner_pkg::DATA_W-1:0] exp_q [NUM_TAGS][$];
    logic [combiner_pkg::DEST_W-1:0] dest_log [$];
    logic                            log_dests;

    // Source control and bookkeeping
    int                    valid_pct;
    logic                  gen_on;
    logic [NUM_INPUTS-1:0] took;
    int                    accept_cnt [NUM_INPUTS];
    int                    out_cnt;
    int                    err_mismatch;
    int                    err_other;
    string                 test_name;

    stream_combiner #(
        .NUM_INPUTS (NUM_INPUTS)
    ) i_dut (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // Input k must leave with the tag last written for it
    function automatic logic [combiner_pkg::DEST_W-1:0] expected_tag(input int k);
        return shadow_tags[k];
    endfunction

    function automatic bit all_idle();
        if (in_valid != '0 || out_valid) return 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (exp_q[t].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    // Every accepted input beat goes to the queue of its expected tag
    always @(posedge clock) begin
        for (int k = 0; k < NUM_INPUTS; k++) begin
            took[k] = arst_n && in_valid[k] && in_ready[k];
            if (took[k]) begin
                exp_q[expected_tag(k)].push_back(in_data[k]);
                accept_cnt[k]++;
            end
        end
    end

    // Comparing process at each output transfer
    always @(posedge clock) begin
        logic [combiner_pkg::DATA_W-1:0] expected;
        if (arst_n && out_valid && out_ready) begin
            out_cnt++;
            if (log_dests) dest_log.push_back(out_beat.dest);
            for (int k = 0; k < NUM_INPUTS; k++) begin
                if (!shadow_mask[k] && out_beat.dest == expected_tag(k)) begin
                    err_other++;
                    $display("%s: beat left with the tag of disabled input %0d", test_name, k);
                end
            end
            if (exp_q[out_beat.dest].size() == 0) begin
                err_other++;
                $display("%s: output beat %h with tag %0d was never sent", test_name,
                         out_beat.data, out_beat.dest);
            end else begin
                expected = exp_q[out_beat.dest].pop_front();
                if (out_beat.data !== expected) begin
                    err_mismatch++;
                    $display("Mismatch in %s: tag %0d data expected %h, actual %h", test_name,
                             out_beat.dest, expected, out_beat.data);
                end
            end
        end
    end

    // Sources hold a beat until it is taken and then may offer a new one
    initial begin
        void'($urandom(32'h3176_bdfd));
        forever begin
            @(negedge clock);
            for (int k = 0; k < NUM_INPUTS; k++) begin
                if (arst_n && (!in_valid[k] || took[k])) begin
                    if (gen_on && ($urandom_range(99) < valid_pct)) begin
                        in_valid[k] = 1'b1;
                        in_data[k]  = $urandom();
                    end else begin
                        in_valid[k] = 1'b0;
                    end
                end
            end
        end
    end

    // A write lasts one cycle and the shadow follows once the edge has passed
    task automatic cfg_write(input logic [3:0] addr, input logic [31:0] word);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = word;
        @(negedge clock);
        cfg_we = 1'b0;
        if (addr == combiner_pkg::CFG_ADDR_CTRL) begin
            shadow_mask = cfg_wdata.ctrl.enable[NUM_INPUTS-1:0];
        end else if (addr < combiner_pkg::CFG_ADDR_TAG_BASE + NUM_INPUTS) begin
            shadow_tags[addr - combiner_pkg::CFG_ADDR_TAG_BASE] = cfg_wdata.tag.dest;
        end
    endtask

    task automatic cfg_check(input logic [3:0] addr, input logic [31:0] expected);
        cfg_addr = addr;
        @(posedge clock);
        if (cfg_rdata !== expected) begin
            err_mismatch++;
            $display("Mismatch in %s: read-back at %0d expected %h, actual %h", test_name,
                     addr, expected, cfg_rdata);
        end
        @(negedge clock);
    endtask

    task automatic wait_transfers(input int n);
        int target;
        int cycles;
        target = out_cnt + n;
        cycles = 0;
        while (out_cnt < target) begin
            if (cycles == TIMEOUT) begin
                err_other++;
                $display("%s: timed out waiting for %0d output transfers", test_name, n);
                break;
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    // Stops the sources and waits until every accepted beat has come out
    task automatic drain();
        int cycles;
        gen_on = 1'b0;
        cycles = 0;
        while (!all_idle()) begin
            if (cycles == TIMEOUT) begin
                err_other++;
                $display("%s: beats still missing after the drain timeout", test_name);
                break;
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    initial begin
        logic [combiner_pkg::DEST_W-1:0] held_dest;
        logic [combiner_pkg::DATA_W-1:0] held_data;
        int base_cnt [NUM_INPUTS];
        int base_out;
        int seen;
        int cycles;
        arst_n       = 1'b1;
        in_valid     = '0;
        in_data      = '0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        out_ready    = 1'b0;
        gen_on       = 1'b0;
        valid_pct    = 0;
        log_dests    = 1'b0;
        took         = '0;
        out_cnt      = 0;
        err_mismatch = 0;
        err_other    = 0;
        shadow_mask  = '1;
        for (int k = 0; k < NUM_INPUTS; k++) begin
            shadow_tags[k] = k;
            accept_cnt[k]  = 0;
        end
        // Reset goes low on the first falling edge and stays low for 16 cycles
        @(negedge clock);
        arst_n = 1'b0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        arst_n    = 1'b1;
        out_ready = 1'b1;

        // Reset values and a zero read from an unmapped address
        test_name = "reset_readback";
        cfg_check(combiner_pkg::CFG_ADDR_CTRL, 32'((1 << NUM_INPUTS) - 1));
        for (int k = 0; k < NUM_INPUTS; k++) cfg_check(1 + k, 32'(k));
        cfg_check(1 + NUM_INPUTS, 32'h0);

        test_name = "random_traffic";
        valid_pct = 50;
        gen_on    = 1'b1;
        wait_transfers(300);
        drain();

        // Permuted unique tags where the odd step 7 keeps k*7+9 from repeating within 16
        test_name = "tag_rewrite";
        for (int k = 0; k < NUM_INPUTS; k++) cfg_write(1 + k, 32'((k * 7 + 9) % NUM_TAGS));
        for (int k = 0; k < NUM_INPUTS; k++) cfg_check(1 + k, 32'((k * 7 + 9) % NUM_TAGS));
        valid_pct = 60;
        gen_on    = 1'b1;
        wait_transfers(200);
        drain();

        // Every input always requests, so each window of six holds every tag once
        test_name = "round_robin";
        valid_pct = 100;
        gen_on    = 1'b1;
        wait_transfers(12);
        dest_log.delete();
        log_dests = 1'b1;
        wait_transfers(36);
        log_dests = 1'b0;
        for (int s = 0; s + NUM_INPUTS <= dest_log.size(); s++) begin
            for (int k = 0; k < NUM_INPUTS; k++) begin
                seen = 0;
                for (int j = s; j < s + NUM_INPUTS; j++) begin
                    if (dest_log[j] == expected_tag(k)) seen++;
                end
                if (seen != 1) begin
                    err_mismatch++;
                    $display("Mismatch in %s: tag %0d count in window %0d expected 1, actual %0d",
                             test_name, expected_tag(k), s, seen);
                end
            end
        end
        drain();

        // Stall with a full output register so no further grant can happen
        test_name = "backpressure";
        valid_pct = 100;
        gen_on    = 1'b1;
        cycles    = 0;
        while (!out_valid && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!out_valid) begin
            err_other++;
            $display("%s: output never became valid", test_name);
        end
        out_ready = 1'b0;
        held_dest = out_beat.dest;
        held_data = out_beat.data;
        base_out  = out_cnt;
        for (int k = 0; k < NUM_INPUTS; k++) base_cnt[k] = accept_cnt[k];
        repeat (50) begin
            @(negedge clock);
            if (!out_valid || out_beat.dest !== held_dest || out_beat.data !== held_data) begin
                err_mismatch++;
                $display("Mismatch in %s: held beat expected %h/%0d, actual %h/%0d", test_name,
                         held_data, held_dest, out_beat.data, out_beat.dest);
            end
        end
        if (out_cnt != base_out) begin
            err_other++;
            $display("%s: output transferred while out_ready was low", test_name);
        end
        for (int k = 0; k < NUM_INPUTS; k++) begin
            if (accept_cnt[k] - base_cnt[k] > 2 || in_ready[k]) begin
                err_other++;
                $display("%s: input %0d took %0d beats while stalled and kept ready %b",
                         test_name, k, accept_cnt[k] - base_cnt[k], in_ready[k]);
            end
        end
        out_ready = 1'b1;
        drain();

        // Input 2 is masked and its beats wait in its buffer until it is enabled again
        test_name = "mask_disable";
        cfg_write(combiner_pkg::CFG_ADDR_CTRL, 32'h3B);
        cfg_check(combiner_pkg::CFG_ADDR_CTRL, 32'h3B);
        valid_pct = 50;
        gen_on    = 1'b1;
        wait_transfers(150);
        gen_on = 1'b0;
        cycles = 0;
        seen   = 1;
        while (seen != 0 && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
            seen = 0;
            for (int k = 0; k < NUM_INPUTS; k++) begin
                if (shadow_mask[k] && (in_valid[k] || exp_q[expected_tag(k)].size() != 0)) seen++;
            end
        end
        if (seen != 0) begin
            err_other++;
            $display("%s: enabled inputs did not drain", test_name);
        end
        if (exp_q[expected_tag(2)].size() == 0) begin
            err_other++;
            $display("%s: the disabled input holds no buffered beats", test_name);
        end
        cfg_write(combiner_pkg::CFG_ADDR_CTRL, 32'h3F);
        drain();

        if (i_dut.i_checker.fail_count != 0) begin
            err_other += i_dut.i_checker.fail_count;
            $display("%0d assertions of the bound checker failed", i_dut.i_checker.fail_count);
        end
        $display("Errors: %0d mismatches, %0d other failures", err_mismatch, err_other);
        if (err_mismatch == 0 && err_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* stream_skid_buffer.sv */
`timescale 1ns/1ps
/*
 * Stream skid buffer
 * Two-entry input stage with a registered ready and full throughput
 */
module stream_skid_buffer (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            in_valid,
    input  logic [combiner_pkg::DATA_W-1:0] in_data,
    output logic                            in_ready,
    output logic                            buf_valid,
    output logic [combiner_pkg::DATA_W-1:0] buf_data,
    input  logic                            buf_ready
);

    // Second entry, only used while the head is stalled
    logic                            skid_valid;
    logic [combiner_pkg::DATA_W-1:0] skid_data;

    logic in_fire;
    logic out_fire;
    logic head_load;
    logic skid_load;
    logic buf_valid_d;
    logic skid_valid_d;

    assign in_fire  = in_valid & in_ready;
    assign out_fire = buf_valid & buf_ready;

    // The head can take a beat when it is empty or drains this cycle
    assign head_load = out_fire | ~buf_valid;

    // A beat arriving while the head stays put parks in the skid entry
    assign skid_load = in_fire & ~head_load;

    // Next occupancy, the skid entry always moves to the head first to keep order
    always_comb begin
        buf_valid_d  = buf_valid;
        skid_valid_d = skid_valid;
        if (head_load) begin
            buf_valid_d  = skid_valid | in_fire;
            skid_valid_d = 1'b0;
        end else if (skid_load) begin
            skid_valid_d = 1'b1;
        end
    end

    // Ready comes from a flop, high whenever the skid entry is free
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            buf_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            buf_valid  <= buf_valid_d;
            skid_valid <= skid_valid_d;
            in_ready   <= ~skid_valid_d;
        end
    end

    // Payload path
    always_ff @(posedge clock) begin
        if (head_load && (skid_valid || in_fire)) begin
            buf_data <= skid_valid ? skid_data : in_data;
        end
        if (skid_load) begin
            skid_data <= in_data;
        end
    end

endmodule
